// File: source/cfr_pkg.sv
/* Common sample, I/Q, peak and pulse-write types for the CFR chain.
   Every RTL block imports what it needs from here. */
package cfr_pkg;

  // Fixed-point layout
  localparam int DATA_WIDTH     = 16;
  localparam int CPW_ADDR_WIDTH = 8;
  localparam int MULT_SHIFT     = 15;
  // Holds a full complex product sum plus the rounding term
  localparam int SAT_WIDTH      = 2 * DATA_WIDTH + 2;

  typedef logic signed [DATA_WIDTH-1:0] sample_t;

  typedef struct packed {
    sample_t q;
    sample_t i;
  } iq_t;

  typedef struct packed {
    iq_t  amp;
    logic phase;
    logic valid;
  } peak_t;

  // Pulse memory write command, stage selects the CPG
  typedef struct packed {
    logic                      en;
    logic [3:0]                stage;
    logic [CPW_ADDR_WIDTH-1:0] addr;
    iq_t                       data;
  } cpw_wr_t;

  // Clamp a wide signed value to the sample range
  function automatic sample_t sat_sample(logic signed [SAT_WIDTH-1:0] x);
    if (x[SAT_WIDTH-1:DATA_WIDTH-1] == '0 || x[SAT_WIDTH-1:DATA_WIDTH-1] == '1) begin
      return x[DATA_WIDTH-1:0];
    end
    return x[SAT_WIDTH-1] ? {1'b1, {(DATA_WIDTH-1){1'b0}}} : {1'b0, {(DATA_WIDTH-1){1'b1}}};
  endfunction

endpackage

// File: source/cfr_pulse_ram.sv
/* Pulse tap memory for one CPG: written from the control port, read by
   the stage with two cycles of latency and a zero output when idle. */
`timescale 1ns/1ps

module cfr_pulse_ram
  import cfr_pkg::*;
#(
  parameter int CPW_ADDR_WIDTH = cfr_pkg::CPW_ADDR_WIDTH
) (
  input  logic                      clk,
  input  logic                      wr_en_i,
  input  logic [CPW_ADDR_WIDTH-1:0] wr_addr_i,
  input  iq_t                       wr_data_i,
  input  logic                      rd_en_i,
  input  logic [CPW_ADDR_WIDTH-1:0] rd_addr_i,
  output iq_t                       rd_data_o
);

  iq_t  mem [2**CPW_ADDR_WIDTH];
  iq_t  rd_q;
  logic rd_en_q;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // Read register, then output register cleared for slots with no read
  always_ff @(posedge clk) begin
    rd_en_q <= rd_en_i;
    if (rd_en_i) begin
      rd_q <= mem[rd_addr_i];
    end
    rd_data_o <= rd_en_q ? rd_q : '0;
  end

endmodule

// File: source/cfr_cmult.sv
/* Three-stage complex multiplier, products then sums then rounded shift
   with saturation back to the sample width. */
`timescale 1ns/1ps

module cfr_cmult
  import cfr_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  iq_t  a_i,
  input  iq_t  b_i,
  output iq_t  p_o
);

  localparam int PROD_W = 2 * DATA_WIDTH;

  typedef logic signed [PROD_W-1:0]    prod_t;
  typedef logic signed [SAT_WIDTH-1:0] acc_t;

  // Half an LSB of the result, for round half up
  localparam acc_t ROUND = acc_t'(1) <<< (MULT_SHIFT - 1);

  prod_t p_ii, p_qq, p_iq, p_qi;
  acc_t  re, im;

  // Stage 1, partial products
  always_ff @(posedge clk) begin
    if (rst) begin
      p_ii <= '0;
      p_qq <= '0;
      p_iq <= '0;
      p_qi <= '0;
    end else begin
      p_ii <= a_i.i * b_i.i;
      p_qq <= a_i.q * b_i.q;
      p_iq <= a_i.i * b_i.q;
      p_qi <= a_i.q * b_i.i;
    end
  end

  // Stage 2, real and imaginary sums
  always_ff @(posedge clk) begin
    if (rst) begin
      re <= '0;
      im <= '0;
    end else begin
      re <= acc_t'(p_ii) - acc_t'(p_qq) + ROUND;
      im <= acc_t'(p_iq) + acc_t'(p_qi) + ROUND;
    end
  end

  // Stage 3
  always_ff @(posedge clk) begin
    if (rst) begin
      p_o <= '0;
    end else begin
      p_o <= '{q: sat_sample(im >>> MULT_SHIFT), i: sat_sample(re >>> MULT_SHIFT)};
    end
  end

endmodule

// File: source/cfr_peak_detect.sv
/* Peak decode stage: finds per-channel local maxima above threshold and
   emits weight and phase aligned with the data, four cycles after input. */
`timescale 1ns/1ps

module cfr_peak_detect
  import cfr_pkg::*;
#(
  parameter int THRESH_WIDTH = 17
) (
  input  logic                    clk,
  input  logic                    rst,
  input  iq_t                     data_i,
  input  logic [THRESH_WIDTH-1:0] thresh_i,
  input  logic [3:0]              gain_shift_i,
  output iq_t                     data_o,
  output peak_t                   peak_o
);

  // |I|+|Q| stays below 2^(DATA_WIDTH+1)
  typedef logic [DATA_WIDTH:0] mag_t;

  typedef struct packed {
    mag_t mag;
    iq_t  iq;
  } win_t;

  // Interleaved history. Entries 0, 2 and 4 share one channel
  // and hold the next, middle and previous samples of it
  win_t  win [5];
  mag_t  mag_in;
  logic  is_peak;
  logic  phase;
  iq_t   weight;

  function automatic mag_t abs_ext(sample_t s);
    logic signed [DATA_WIDTH:0] e;
    e = {s[DATA_WIDTH-1], s};
    return (e < 0) ? mag_t'(-e) : mag_t'(e);
  endfunction

  // Negate first, then shift; only -full scale at shift 0 can overflow
  function automatic sample_t neg_shift(sample_t s, logic [3:0] sh);
    logic signed [DATA_WIDTH:0] n;
    n = -$signed({s[DATA_WIDTH-1], s});
    n = n >>> sh;
    return sat_sample(SAT_WIDTH'(n));
  endfunction

  assign mag_in = abs_ext(data_i.i) + abs_ext(data_i.q);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < 5; k++) begin
        win[k] <= '0;
      end
    end else begin
      win[0] <= '{mag: mag_in, iq: data_i};
      for (int k = 1; k < 5; k++) begin
        win[k] <= win[k-1];
      end
    end
  end

  // **************************************************************************
  // Peak test on the middle entry
  // **************************************************************************
  assign is_peak = (win[2].mag > thresh_i) && (win[2].mag > win[4].mag) &&
                   (win[2].mag >= win[0].mag);
  assign phase   = win[0].mag > win[4].mag;
  assign weight  = '{q: neg_shift(win[2].iq.q, gain_shift_i),
                     i: neg_shift(win[2].iq.i, gain_shift_i)};

  always_ff @(posedge clk) begin
    if (rst) begin
      data_o <= '0;
      peak_o <= '0;
    end else begin
      data_o       <= win[2].iq;
      peak_o.valid <= is_peak;
      peak_o.phase <= is_peak & phase;
      peak_o.amp   <= is_peak ? weight : '0;
    end
  end

endmodule

// File: source/cfr_cpg.sv
/* Cascadable canceling pulse generator serving two interleaved channels.
   Takes one peak per channel when idle and forwards the rest downstream. */
`timescale 1ns/1ps

module cfr_cpg
  import cfr_pkg::*;
#(
  parameter int CPW_ADDR_WIDTH = cfr_pkg::CPW_ADDR_WIDTH,
  parameter int STAGE          = 0
) (
  input  logic    clk,
  input  logic    rst,
  input  iq_t     data_i,
  input  peak_t   peak_i,
  input  cpw_wr_t cpw_wr_i,
  output iq_t     data_o,
  output peak_t   peak_o
);

  // Address bit 0 is the phase, the rest count taps
  localparam int TAP_W = CPW_ADDR_WIDTH - 1;

  typedef struct packed {
    logic             busy;
    logic [TAP_W-1:0] tap;
    logic             phase;
    iq_t              amp;
  } slot_t;

  // cur belongs to the channel of data_i, nxt to the other one
  slot_t cur;
  slot_t nxt;
  logic  accept;
  logic  last_tap;
  logic  wr_en;
  iq_t   amp_d1;
  iq_t   amp_d2;
  iq_t   tap_data;
  iq_t   delta;

  function automatic sample_t add_sat(sample_t a, sample_t b);
    logic signed [DATA_WIDTH:0] s;
    s = a + b;
    return sat_sample(SAT_WIDTH'(s));
  endfunction

  // **************************************************************************
  // Per-channel state rotation
  // **************************************************************************
  assign accept   = peak_i.valid && !cur.busy;
  assign last_tap = &cur.tap;

  always_ff @(posedge clk) begin
    if (rst) begin
      cur <= '0;
      nxt <= '0;
    end else begin
      cur <= nxt;
      if (accept) begin
        nxt <= '{busy: 1'b1, tap: '0, phase: peak_i.phase, amp: peak_i.amp};
      end else if (cur.busy && !last_tap) begin
        nxt <= '{busy: 1'b1, tap: cur.tap + 1'b1, phase: cur.phase, amp: cur.amp};
      end else begin
        nxt <= '0;
      end
    end
  end

  // Busy channel passes the peak on untouched
  always_ff @(posedge clk) begin
    if (rst) begin
      peak_o <= '0;
    end else if (peak_i.valid && cur.busy) begin
      peak_o <= peak_i;
    end else begin
      peak_o <= '0;
    end
  end

  // **************************************************************************
  // Pulse read, scaling and summation
  // **************************************************************************
  assign wr_en = cpw_wr_i.en && (cpw_wr_i.stage == 4'(STAGE));

  cfr_pulse_ram #(
    .CPW_ADDR_WIDTH(CPW_ADDR_WIDTH)
  ) pulse_ram_i (
    .clk      (clk),
    .wr_en_i  (wr_en),
    .wr_addr_i(cpw_wr_i.addr),
    .wr_data_i(cpw_wr_i.data),
    .rd_en_i  (nxt.busy),
    .rd_addr_i({nxt.tap, ~nxt.phase}),
    .rd_data_o(tap_data)
  );

  // Match the two-cycle memory latency
  always_ff @(posedge clk) begin
    amp_d1 <= nxt.amp;
    amp_d2 <= amp_d1;
  end

  cfr_cmult cmult_i (
    .clk(clk),
    .rst(rst),
    .a_i(amp_d2),
    .b_i(tap_data),
    .p_o(delta)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      data_o <= '0;
    end else begin
      data_o <= '{q: add_sat(data_i.q, delta.q), i: add_sat(data_i.i, delta.i)};
    end
  end

endmodule

// File: source/cfr_top.sv
/* CFR peak cancellation top: peak detector followed by a chain of
   N_CPG pulse generators; unplaced peaks show up on peak_drop_o. */
`timescale 1ns/1ps

module cfr_top
  import cfr_pkg::*;
#(
  parameter int N_CPG        = 4,
  parameter int THRESH_WIDTH = DATA_WIDTH + 1
) (
  input  logic                    clk,
  input  logic                    rst,
  input  iq_t                     data_i,
  input  logic [THRESH_WIDTH-1:0] thresh_i,
  input  logic [3:0]              gain_shift_i,
  input  cpw_wr_t                 cpw_wr_i,
  output iq_t                     data_o,
  output logic                    peak_drop_o
);

  // Element k feeds stage k, the last one leaves the chain
  iq_t   chain_data [N_CPG+1];
  peak_t chain_peak [N_CPG+1];

  cfr_peak_detect #(
    .THRESH_WIDTH(THRESH_WIDTH)
  ) peak_detect_i (
    .clk         (clk),
    .rst         (rst),
    .data_i      (data_i),
    .thresh_i    (thresh_i),
    .gain_shift_i(gain_shift_i),
    .data_o      (chain_data[0]),
    .peak_o      (chain_peak[0])
  );

  // **************************************************************************
  // CPG cascade
  // **************************************************************************
  for (genvar k = 0; k < N_CPG; k++) begin : g_cpg
    cfr_cpg #(
      .CPW_ADDR_WIDTH(CPW_ADDR_WIDTH),
      .STAGE         (k)
    ) cpg_i (
      .clk     (clk),
      .rst     (rst),
      .data_i  (chain_data[k]),
      .peak_i  (chain_peak[k]),
      .cpw_wr_i(cpw_wr_i),
      .data_o  (chain_data[k+1]),
      .peak_o  (chain_peak[k+1])
    );
  end

  assign data_o      = chain_data[N_CPG];
  assign peak_drop_o = chain_peak[N_CPG].valid;

endmodule

// File: tests/cfr_top_properties.sv
/* Concurrent checks on the CPG peak handoff, bound into every stage. */
`timescale 1ns/1ps

module cfr_top_properties
  import cfr_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input logic  accept_i,
  input peak_t peak_in_i,
  input peak_t peak_out_i
);

  // An accepted peak ends at this stage
  assert property (@(posedge clk) disable iff (rst) accept_i |=> !peak_out_i.valid)
    else $error("CPG forwarded a peak that it accepted");

  // Empty handoff slots carry no stale weight or phase
  assert property (@(posedge clk) disable iff (rst)
    !peak_out_i.valid |-> (peak_out_i.amp == '0 && !peak_out_i.phase))
    else $error("CPG peak output has nonzero fields while valid is low");

  assert property (@(posedge clk) rst |=> !peak_out_i.valid)
    else $error("CPG peak output valid during reset");

  // Out of reset a forwarded peak needs an input peak one cycle before
  assert property (@(posedge clk) disable iff (rst) peak_out_i.valid |-> $past(peak_in_i.valid))
    else $error("CPG peak output valid without an input peak");

endmodule

bind cfr_cpg cfr_top_properties properties_i (
  .clk       (clk),
  .rst       (rst),
  .accept_i  (accept),
  .peak_in_i (peak_i),
  .peak_out_i(peak_o)
);

// File: tests/cfr_top_tb.sv
/* Table-driven testbench for cfr_top with peak scenarios on a random background,
   checked cycle by cycle against a reference model of the cancellation. */
`timescale 1ns/1ps

module cfr_top_tb import cfr_pkg::*; ();

  localparam int N_CPG = 2;
  localparam int LAT   = 4 + N_CPG;
  localparam int NX    = 360;
  localparam int NT    = 6;

  logic        clk = 1'b0;
  logic        rst;
  iq_t         data_i;
  logic [16:0] thresh_i;
  logic [3:0]  gain_shift_i;
  cpw_wr_t     cpw_wr_i;
  iq_t         data_o;
  logic        peak_drop_o;

  // Each peak is {cycle, channel, sample {q,i}, shoulder after}
  // Cycle 0 marks an unused entry
  string t_name   [NT] = '{"passthrough", "ch0_phase0", "ch0_phase1",
                           "both_channels", "busy_and_drop", "saturate_rewrite"};
  int    t_thresh [NT] = '{131071, 2000, 2000, 2000, 2000, 2000};
  int    t_shift  [NT] = '{0, 1, 2, 1, 2, 0};
  bit    t_rewrite[NT] = '{0, 0, 0, 0, 0, 1};
  int    t_peak   [NT][3][4] = '{
    '{'{0, 0, 0, 0}, '{0, 0, 0, 0}, '{0, 0, 0, 0}},
    '{'{10, 0, 32'h1800_E000, 0}, '{0, 0, 0, 0}, '{0, 0, 0, 0}},
    '{'{10, 0, 32'hD000_2400, 1}, '{0, 0, 0, 0}, '{0, 0, 0, 0}},
    '{'{10, 0, 32'h2000_1000, 0}, '{10, 1, 32'hE000_3000, 1}, '{0, 0, 0, 0}},
    '{'{10, 0, 32'h2800_D800, 1}, '{20, 0, 32'h3000_2000, 0}, '{30, 0, 32'hC800_3800, 1}},
    '{'{10, 0, 32'h8000_8000, 1}, '{12, 1, 32'h7FFF_8000, 0}, '{0, 0, 0, 0}}};

  logic [31:0] pulse [N_CPG][256];
  logic [31:0] stim  [NX];
  logic [31:0] expd  [NX];
  logic        drop  [NX];
  int          add_i [N_CPG][NX];
  int          add_q [N_CPG][NX];

  cfr_top #(
    .N_CPG(N_CPG)
  ) cfr_top_i (
    .clk         (clk),
    .rst         (rst),
    .data_i      (data_i),
    .thresh_i    (thresh_i),
    .gain_shift_i(gain_shift_i),
    .cpw_wr_i    (cpw_wr_i),
    .data_o      (data_o),
    .peak_drop_o (peak_drop_o)
  );

  always #50 clk = ~clk;

  task automatic check_value(string what, logic [31:0] expv, logic [31:0] actv);
    if (actv !== expv) begin
      $display("[FAIL] %s: expected %h, actual %h", what, expv, actv);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // **************************************************************************
  // Sample arithmetic for the reference model
  // **************************************************************************
  function automatic int comp(logic [31:0] s, bit hi);
    return hi ? int'($signed(s[31:16])) : int'($signed(s[15:0]));
  endfunction

  function automatic int mag(int n);
    int vi, vq;
    vi = (n < 0) ? 0 : comp(stim[n], 0);
    vq = (n < 0) ? 0 : comp(stim[n], 1);
    return (vi < 0 ? -vi : vi) + (vq < 0 ? -vq : vq);
  endfunction

  function automatic int clamp(longint v);
    if (v > 32767) return 32767;
    if (v < -32768) return -32768;
    return int'(v);
  endfunction

  // Round half up, then drop the fraction bits
  function automatic int scale(longint p);
    return clamp((p + (longint'(1) <<< (MULT_SHIFT - 1))) >>> MULT_SHIFT);
  endfunction

  function automatic logic [31:0] halve(logic [31:0] s);
    return {$signed(s[31:16]) >>> 1, $signed(s[15:0]) >>> 1};
  endfunction

  function automatic logic [15:0] rail();
    return ($urandom_range(1) != 0) ? 16'h7FFF : 16'h8000;
  endfunction

  // Full-scale taps drive the multiplier and adder into saturation
  task automatic write_pulse(int k, bit extreme);
    logic [31:0] d;
    for (int a = 0; a < 256; a++) begin
      d = extreme ? {rail(), rail()} : halve(halve($urandom));
      @(posedge clk);
      cpw_wr_i <= '{en: 1'b1, stage: 4'(k), addr: 8'(a), data: d};
      pulse[k][a] = d;
    end
    @(posedge clk);
    cpw_wr_i <= '0;
  endtask

  task automatic build_stim(int t);
    int n;
    for (int k = 0; k < NX; k++) begin
      stim[k] = {16'($urandom_range(127)) - 16'd64, 16'($urandom_range(127)) - 16'd64};
    end
    // A half-size shoulder on one side fixes the phase of each peak
    for (int p = 0; p < 3; p++) begin
      if (t_peak[t][p][0] != 0) begin
        n = 2 * t_peak[t][p][0] + t_peak[t][p][1];
        stim[n] = t_peak[t][p][2];
        stim[(t_peak[t][p][3] != 0) ? n + 2 : n - 2] = halve(stim[n]);
      end
    end
  endtask

  task automatic run_model(int t);
    int          busy [N_CPG][2];
    int          wi, wq, ti, tq, vi, vq, m;
    bit          ph, placed;
    logic [31:0] tap;
    for (int k = 0; k < N_CPG; k++) begin
      busy[k][0] = -1000;
      busy[k][1] = -1000;
      for (int n = 0; n < NX; n++) begin
        add_i[k][n] = 0;
        add_q[k][n] = 0;
      end
    end
    for (int n = 0; n < NX; n++) begin
      drop[n] = 1'b0;
    end
    for (int n = 0; n < NX - 2; n++) begin
      if (mag(n) > t_thresh[t] && mag(n) > mag(n - 2) && mag(n) >= mag(n + 2)) begin
        ph = mag(n + 2) > mag(n - 2);
        wi = clamp(longint'(-comp(stim[n], 0) >>> t_shift[t]));
        wq = clamp(longint'(-comp(stim[n], 1) >>> t_shift[t]));
        placed = 1'b0;
        for (int k = 0; k < N_CPG; k++) begin
          if (!placed && n > busy[k][n % 2]) begin
            placed = 1'b1;
            busy[k][n % 2] = n + 256;
            for (int a = 0; a < 128; a++) begin
              m   = n + 2 * a + 6;
              tap = pulse[k][8'(2 * a + (ph ? 0 : 1))];
              ti  = comp(tap, 0);
              tq  = comp(tap, 1);
              if (m < NX) begin
                add_i[k][m] = scale(longint'(wi) * ti - longint'(wq) * tq);
                add_q[k][m] = scale(longint'(wi) * tq + longint'(wq) * ti);
              end
            end
          end
        end
        drop[n] = !placed;
      end
    end
    for (int n = 0; n < NX; n++) begin
      vi = comp(stim[n], 0);
      vq = comp(stim[n], 1);
      for (int k = 0; k < N_CPG; k++) begin
        vi = clamp(longint'(vi + add_i[k][n]));
        vq = clamp(longint'(vq + add_q[k][n]));
      end
      expd[n] = {16'(vq), 16'(vi)};
    end
  endtask

  // Data still in the pipeline has to be gone after the first reset edge
  task automatic reset_dut(string why);
    @(posedge clk);
    rst    <= 1'b1;
    data_i <= '0;
    @(posedge clk);
    @(negedge clk);
    check_value({why, " reset data_o"}, 32'd0, data_o);
    check_value({why, " reset peak_drop_o"}, 32'd0, 32'(peak_drop_o));
    repeat (15) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic run_test(int t);
    string lbl;
    for (int c = 0; c < NX; c++) begin
      @(posedge clk);
      data_i <= stim[c];
      @(negedge clk);
      if (c >= LAT) begin
        lbl = $sformatf("%s sample %0d", t_name[t], c - LAT);
        check_value({lbl, " data_o"}, expd[c - LAT], data_o);
        check_value({lbl, " peak_drop_o"}, 32'(drop[c - LAT]), 32'(peak_drop_o));
      end
    end
  endtask

  // **************************************************************************
  // Test sequence
  // **************************************************************************
  initial begin
    rst          = 1'b1;
    data_i       = '0;
    thresh_i     = '1;
    gain_shift_i = '0;
    cpw_wr_i     = '0;
    void'($urandom(32'h6830));
    reset_dut("startup");
    for (int k = 0; k < N_CPG; k++) begin
      write_pulse(k, 1'b0);
    end
    for (int t = 0; t < NT; t++) begin
      if (t_rewrite[t]) begin
        for (int k = 0; k < N_CPG; k++) begin
          write_pulse(k, 1'b1);
        end
      end
      @(posedge clk);
      thresh_i     <= 17'(t_thresh[t]);
      gain_shift_i <= 4'(t_shift[t]);
      build_stim(t);
      run_model(t);
      reset_dut(t_name[t]);
      run_test(t);
    end
    $display("all tests passed");
    $finish;
  end

  // Run limit well past the length of all tests
  initial begin
    #2_000_000;
    $display("Timeout: the run did not finish within its time limit");
    $display("tests failed");
    $fatal(1, "timeout");
  end

endmodule

// File: cfr_top.f
source/cfr_pkg.sv
source/cfr_pulse_ram.sv
source/cfr_cmult.sv
source/cfr_peak_detect.sv
source/cfr_cpg.sv
source/cfr_top.sv
tests/cfr_top_properties.sv
tests/cfr_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the CFR testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f cfr_top.f --top-module cfr_top_tb -o cfr_top_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cfr_top_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
  echo "Simulation result: FAIL"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "Simulation result: PASS"
exit 0
